/* list.f */
rtl/int_pkg.sv
rtl/reg_bus_slave.sv
rtl/int_regfile.sv
rtl/plic.sv
rtl/clint.sv
rtl/int_ctrl.sv
rtl/int_top.sv
sim/tb_int_top.sv

/* rtl/clint.sv */
// core-local interruptor, counts trigger edges in mtime and drives timer and software lines
`timescale 1ns/10ps
`default_nettype none

module clint (
  input  wire            logic clk,
  input  wire            logic rst,
  input  wire            logic trigger,   // slow time base
  input  int_pkg::time_t mtimecmp,
  input  wire            logic msip,
  output int_pkg::time_t mtime,
  output logic           tmr,
  output logic           sft
);

  logic trig_q;
  logic trig_qq;
  logic trig_rise;

  assign trig_rise = trig_q & ~trig_qq;

  always_ff @(posedge clk) begin
    if (rst) begin
      trig_q  <= 1'b0;
      trig_qq <= 1'b0;
      mtime   <= '0;
    end else begin
      trig_q  <= trigger;
      trig_qq <= trig_q;
      if (trig_rise) begin
        mtime <= mtime + 64'd1;  // one tick per rising edge
      end
    end
  end

  assign tmr = (mtime >= mtimecmp);  // no register, follows compare writes at once
  assign sft = msip;

endmodule

`default_nettype wire

/* rtl/int_ctrl.sv */
// masks the interrupt lines, orders them and hands a trap request to the core over four-phase
`timescale 1ns/10ps
`default_nettype none

module int_ctrl (
  input  wire                 logic clk,
  input  wire                 logic rst,
  input  int_pkg::irq_lines_t lines,
  input  int_pkg::core_csr_t  core_csr,
  output logic                trap_req,
  output int_pkg::core_trap_t trap,
  input  wire                 logic trap_ack
);

  import int_pkg::*;

  int_state_e state;
  logic       ext_ok;
  logic       sft_ok;
  logic       tmr_ok;
  data_t      cause;

  // --------------------
  // masking
  assign ext_ok = lines.ext & core_csr.meie & core_csr.mie;
  assign sft_ok = lines.sft & core_csr.msie & core_csr.mie;
  assign tmr_ok = lines.tmr & core_csr.mtie & core_csr.mie;

  always_comb begin
    if (ext_ok) begin
      cause = CAUSE_MEI;
    end else if (sft_ok) begin
      cause = CAUSE_MSI;
    end else begin
      cause = CAUSE_MTI;
    end
  end

  // --------------------
  // trap handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:         if (ext_ok || sft_ok || tmr_ok) state <= REQ;
        REQ:          if (trap_ack) state <= WAIT_RELEASE;
        WAIT_RELEASE: if (!trap_ack) state <= IDLE;  // core must drop ack first
        default:      state <= IDLE;
      endcase
    end
  end

  // trap contents frozen while the request is out
  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      trap.cause  <= cause;
      trap.epc    <= core_csr.pc;
      trap.target <= {core_csr.mtvec[31:2], 2'b00};  // direct mode only
    end
  end

  assign trap_req = (state == REQ);

endmodule

`default_nettype wire

/* rtl/int_pkg.sv */
// shared types, register map and cause codes for the interrupt unit, imported by every rtl block
`default_nettype none

package int_pkg;

  // --------------------
  // widths
  localparam int PRIO_W = 3;  // register map depends on this

  typedef logic [31:0]       data_t;
  typedef logic [7:0]        addr_t;    // word address
  typedef logic [PRIO_W-1:0] prio_t;    // 0 = never
  typedef logic [7:0]        irq_id_t;  // 0 = none
  typedef logic [63:0]       time_t;

  // --------------------
  // bundles
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
  } reg_req_t;

  typedef struct packed {
    logic ext;
    logic sft;
    logic tmr;
  } irq_lines_t;

  typedef struct packed {
    logic  mie;   // global enable from mstatus
    logic  meie;
    logic  msie;
    logic  mtie;
    data_t mtvec;
    data_t pc;
  } core_csr_t;

  typedef struct packed {
    data_t cause;
    data_t epc;
    data_t target;
  } core_trap_t;

  // --------------------
  // register map
  localparam addr_t ADDR_MSIP        = 8'h00;
  localparam addr_t ADDR_MTIMECMP_LO = 8'h01;
  localparam addr_t ADDR_MTIMECMP_HI = 8'h02;
  localparam addr_t ADDR_MTIME_LO    = 8'h03;  // read only
  localparam addr_t ADDR_MTIME_HI    = 8'h04;  // read only
  localparam addr_t ADDR_PENDING     = 8'h08;  // read only
  localparam addr_t ADDR_ENABLE      = 8'h09;
  localparam addr_t ADDR_THRESHOLD   = 8'h0A;
  localparam addr_t ADDR_CLAIM       = 8'h0B;  // read = claim, write = complete
  localparam addr_t ADDR_PRIO_BASE   = 8'h10;  // source i at base + i

  // machine interrupt causes
  localparam data_t CAUSE_MEI = 32'h8000000B;
  localparam data_t CAUSE_MSI = 32'h80000003;
  localparam data_t CAUSE_MTI = 32'h80000007;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_RELEASE
  } int_state_e;

endpackage

`default_nettype wire

/* rtl/int_regfile.sv */
// software visible interrupt registers with address decode, read mux and claim/complete strobes
`timescale 1ns/10ps
`default_nettype none

module int_regfile #(
  parameter int IRQ_NUM = 8
) (
  input  wire                logic clk,
  input  wire                logic rst,
  input  wire                logic reg_access,
  input  int_pkg::reg_req_t  reg_cmd,
  output int_pkg::data_t     reg_rdata,
  // plic side
  input  wire                logic [IRQ_NUM:1] pending,
  input  int_pkg::irq_id_t   best_id,
  output logic [IRQ_NUM:1]   enable,
  output logic [IRQ_NUM*int_pkg::PRIO_W-1:0] prio,
  output int_pkg::prio_t     threshold,
  output logic               claim,
  output logic               complete,
  output int_pkg::irq_id_t   complete_id,
  // clint side
  input  int_pkg::time_t     mtime,
  output int_pkg::time_t     mtimecmp,
  output logic               msip
);

  import int_pkg::*;

  logic wr_en;
  logic rd_en;
  logic id_ok;  // complete id within 1..IRQ_NUM

  assign wr_en = reg_access & reg_cmd.write;
  assign rd_en = reg_access & ~reg_cmd.write;

  // --------------------
  // claim / complete
  assign complete_id = reg_cmd.data[7:0];
  assign id_ok       = (complete_id != '0) && (complete_id <= IRQ_NUM);
  assign claim       = rd_en && (reg_cmd.addr == ADDR_CLAIM);
  assign complete    = wr_en && (reg_cmd.addr == ADDR_CLAIM) && id_ok;

  // --------------------
  // writable registers
  always_ff @(posedge clk) begin
    if (rst) begin
      msip      <= 1'b0;
      mtimecmp  <= '1;  // no timer interrupt out of reset
      enable    <= '0;
      threshold <= '0;
      prio      <= '0;
    end else if (wr_en) begin
      case (reg_cmd.addr)
        ADDR_MSIP:        msip            <= reg_cmd.data[0];
        ADDR_MTIMECMP_LO: mtimecmp[31:0]  <= reg_cmd.data;
        ADDR_MTIMECMP_HI: mtimecmp[63:32] <= reg_cmd.data;
        ADDR_ENABLE:      enable          <= reg_cmd.data[IRQ_NUM:1];
        ADDR_THRESHOLD:   threshold       <= reg_cmd.data[PRIO_W-1:0];
        default: begin
          for (int i = 1; i <= IRQ_NUM; i++) begin
            if (reg_cmd.addr == addr_t'(ADDR_PRIO_BASE + i)) begin
              prio[(i-1)*PRIO_W +: PRIO_W] <= reg_cmd.data[PRIO_W-1:0];
            end
          end
        end
      endcase
    end
  end

  // --------------------
  // read mux, unmapped reads give 0
  always_comb begin
    reg_rdata = '0;
    case (reg_cmd.addr)
      ADDR_MSIP:        reg_rdata = data_t'(msip);
      ADDR_MTIMECMP_LO: reg_rdata = mtimecmp[31:0];
      ADDR_MTIMECMP_HI: reg_rdata = mtimecmp[63:32];
      ADDR_MTIME_LO:    reg_rdata = mtime[31:0];
      ADDR_MTIME_HI:    reg_rdata = mtime[63:32];
      ADDR_PENDING:     reg_rdata = data_t'({pending, 1'b0});  // bit i = source i
      ADDR_ENABLE:      reg_rdata = data_t'({enable, 1'b0});
      ADDR_THRESHOLD:   reg_rdata = data_t'(threshold);
      ADDR_CLAIM:       reg_rdata = data_t'(best_id);
      default: begin
        for (int i = 1; i <= IRQ_NUM; i++) begin
          if (reg_cmd.addr == addr_t'(ADDR_PRIO_BASE + i)) begin
            reg_rdata = data_t'(prio[(i-1)*PRIO_W +: PRIO_W]);
          end
        end
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/int_top.sv */
// top of the interrupt unit, wires bus endpoint, register file, plic, clint and trap control
`timescale 1ns/10ps
`default_nettype none

module int_top #(
  parameter int IRQ_NUM = 8  // external sources, 1 to 31
) (
  input  wire                 logic clk,
  input  wire                 logic rst,
  input  wire                 logic [IRQ_NUM:1] ext_irq,
  input  wire                 logic trigger,
  // register bus
  input  wire                 logic bus_req,
  input  int_pkg::reg_req_t   bus_cmd,
  output logic                bus_ack,
  output int_pkg::data_t      bus_rdata,
  // core
  input  int_pkg::core_csr_t  core_csr,
  output int_pkg::irq_lines_t irq_pend,
  output logic                trap_req,
  output int_pkg::core_trap_t trap,
  input  wire                 logic trap_ack
);

  import int_pkg::*;

  logic                      reg_access;
  reg_req_t                  reg_cmd;
  data_t                     reg_rdata;
  logic [IRQ_NUM:1]          pending;
  irq_id_t                   best_id;
  logic [IRQ_NUM:1]          enable;
  logic [IRQ_NUM*PRIO_W-1:0] prio;
  prio_t                     threshold;
  logic                      claim;
  logic                      complete;
  irq_id_t                   complete_id;
  time_t                     mtime;
  time_t                     mtimecmp;
  logic                      msip;
  logic                      ext;
  logic                      sft;
  logic                      tmr;

  assign irq_pend = '{ext: ext, sft: sft, tmr: tmr};  // also the core's pending view

  reg_bus_slave reg_bus_slave_i (
    .clk       (clk),
    .rst       (rst),
    .bus_req   (bus_req),
    .bus_cmd   (bus_cmd),
    .bus_ack   (bus_ack),
    .bus_rdata (bus_rdata),
    .reg_access(reg_access),
    .reg_cmd   (reg_cmd),
    .reg_rdata (reg_rdata)
  );

  int_regfile #(
    .IRQ_NUM(IRQ_NUM)
  ) int_regfile_i (
    .clk        (clk),
    .rst        (rst),
    .reg_access (reg_access),
    .reg_cmd    (reg_cmd),
    .reg_rdata  (reg_rdata),
    .pending    (pending),
    .best_id    (best_id),
    .enable     (enable),
    .prio       (prio),
    .threshold  (threshold),
    .claim      (claim),
    .complete   (complete),
    .complete_id(complete_id),
    .mtime      (mtime),
    .mtimecmp   (mtimecmp),
    .msip       (msip)
  );

  plic #(
    .IRQ_NUM(IRQ_NUM)
  ) plic_i (
    .clk        (clk),
    .rst        (rst),
    .ext_irq    (ext_irq),
    .enable     (enable),
    .prio       (prio),
    .threshold  (threshold),
    .claim      (claim),
    .complete   (complete),
    .complete_id(complete_id),
    .pending    (pending),
    .best_id    (best_id),
    .ext        (ext)
  );

  clint clint_i (
    .clk     (clk),
    .rst     (rst),
    .trigger (trigger),
    .mtimecmp(mtimecmp),
    .msip    (msip),
    .mtime   (mtime),
    .tmr     (tmr),
    .sft     (sft)
  );

  int_ctrl int_ctrl_i (
    .clk     (clk),
    .rst     (rst),
    .lines   (irq_pend),
    .core_csr(core_csr),
    .trap_req(trap_req),
    .trap    (trap),
    .trap_ack(trap_ack)
  );

endmodule

`default_nettype wire

/* rtl/plic.sv */
// external interrupt gateways, pending bits and priority arbiter of the platform controller
`timescale 1ns/10ps
`default_nettype none

module plic #(
  parameter int IRQ_NUM = 8
) (
  input  wire              logic clk,
  input  wire              logic rst,
  input  wire              logic [IRQ_NUM:1] ext_irq,
  input  wire              logic [IRQ_NUM:1] enable,
  input  wire              logic [IRQ_NUM*int_pkg::PRIO_W-1:0] prio,
  input  int_pkg::prio_t   threshold,
  input  wire              logic claim,
  input  wire              logic complete,
  input  int_pkg::irq_id_t complete_id,
  output logic [IRQ_NUM:1] pending,
  output int_pkg::irq_id_t best_id,
  output logic             ext
);

  import int_pkg::*;

  logic [IRQ_NUM:1] gate_open;  // closed from claim until complete
  prio_t            best_prio;

  // --------------------
  // gateways and pending
  always_ff @(posedge clk) begin
    if (rst) begin
      pending   <= '0;
      gate_open <= '1;
    end else begin
      for (int i = 1; i <= IRQ_NUM; i++) begin
        if (ext_irq[i] && gate_open[i]) begin
          pending[i] <= 1'b1;
        end
        // claim wins over a new set on the same edge
        if (claim && (best_id == irq_id_t'(i))) begin
          pending[i]   <= 1'b0;
          gate_open[i] <= 1'b0;
        end
        if (complete && (complete_id == irq_id_t'(i))) begin
          gate_open[i] <= 1'b1;
        end
      end
    end
  end

  // --------------------
  // arbiter: strictly above threshold, ties to lowest id
  always_comb begin
    best_prio = threshold;
    best_id   = '0;
    for (int i = 1; i <= IRQ_NUM; i++) begin
      if (pending[i] && enable[i] && (prio[(i-1)*PRIO_W +: PRIO_W] > best_prio)) begin
        best_prio = prio[(i-1)*PRIO_W +: PRIO_W];
        best_id   = irq_id_t'(i);
      end
    end
  end

  assign ext = (best_id != '0);

endmodule

`default_nettype wire

/* rtl/reg_bus_slave.sv */
// four-phase req/ack register bus endpoint, issues one register access strobe per transfer
`timescale 1ns/10ps
`default_nettype none

module reg_bus_slave (
  input  wire                logic clk,
  input  wire                logic rst,
  // register bus
  input  wire                logic bus_req,
  input  int_pkg::reg_req_t  bus_cmd,
  output logic               bus_ack,
  output int_pkg::data_t     bus_rdata,
  // towards the register file
  output logic               reg_access,
  output int_pkg::reg_req_t  reg_cmd,
  input  int_pkg::data_t     reg_rdata
);

  logic req_q;  // sampled bus_req
  logic busy;   // transfer in flight until ack drops
  logic start;

  assign start = req_q & ~busy;

  // --------------------
  // handshake control
  always_ff @(posedge clk) begin
    if (rst) begin
      req_q      <= 1'b0;
      busy       <= 1'b0;
      reg_access <= 1'b0;
      bus_ack    <= 1'b0;
    end else begin
      req_q      <= bus_req;
      reg_access <= start;  // single cycle strobe
      if (start) begin
        busy <= 1'b1;
      end
      if (reg_access) begin
        bus_ack <= 1'b1;  // same edge the register write lands
      end else if (bus_ack && !req_q) begin
        bus_ack <= 1'b0;
        busy    <= 1'b0;
      end
    end
  end

  // --------------------
  // command and read data
  always_ff @(posedge clk) begin
    if (start) begin
      reg_cmd <= bus_cmd;  // master holds it stable anyway
    end
    if (reg_access) begin
      bus_rdata <= reg_rdata;  // stays put while ack is high
    end
  end

endmodule

`default_nettype wire

/* sim/tb_int_top.sv */
// testbench for int_top, drives the register bus and a core agent and checks every response
`timescale 1ns/10ps
`default_nettype none

module tb_int_top;

  import int_pkg::*;

  localparam int IRQ_NUM     = 8;
  localparam int CLK_PERIOD  = 100;
  localparam int XFER_CYCLES = 8;   // one four-phase transfer, rounded up
  localparam int ROUNDS      = 12;  // arbitration rounds
  localparam int COMBOS      = 16;  // trap combinations
  localparam int DRAIN_XFERS = 2 * IRQ_NUM + 3;
  localparam int TEST_CYCLES = XFER_CYCLES * (70 + ROUNDS * (DRAIN_XFERS + IRQ_NUM + 4)
                               + 2 * DRAIN_XFERS + 20 + COMBOS * 4) + COMBOS * 40 + 100;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 2000;

  logic             clk = 1'b0;
  logic             rst;
  logic [IRQ_NUM:1] ext_irq;
  logic             trigger;
  logic             bus_req;
  reg_req_t         bus_cmd;
  logic             bus_ack;
  data_t            bus_rdata;
  core_csr_t        core_csr;
  irq_lines_t       irq_pend;
  logic             trap_req;
  core_trap_t       trap;
  logic             trap_ack;

  int          errors = 0;
  int          checks = 0;
  logic [31:0] main_lfsr = 32'h9852fc15;
  logic [31:0] core_lfsr = 32'h9852fc15;  // own stream for the core agent
  core_trap_t  trap_log[$];
  prio_t       prio_model[1:IRQ_NUM];
  logic [IRQ_NUM:1] en_model;
  prio_t       thr_model;

  always #(CLK_PERIOD / 2) clk = ~clk;

  int_top #(
    .IRQ_NUM(IRQ_NUM)
  ) int_top_i (
    .clk      (clk),
    .rst      (rst),
    .ext_irq  (ext_irq),
    .trigger  (trigger),
    .bus_req  (bus_req),
    .bus_cmd  (bus_cmd),
    .bus_ack  (bus_ack),
    .bus_rdata(bus_rdata),
    .core_csr (core_csr),
    .irq_pend (irq_pend),
    .trap_req (trap_req),
    .trap     (trap),
    .trap_ack (trap_ack)
  );

  // --------------------
  // helpers
  function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      state = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);  // galois step
      v = {v[30:0], state[0]};
    end
    return v;
  endfunction

  task automatic report_failure(input string what);
    errors++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  task automatic check_value(input string name, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic bus_transfer(input logic wr, input addr_t a, input data_t d,
                              output data_t rd);
    @(posedge clk);
    bus_req <= 1'b1;
    bus_cmd <= '{write: wr, addr: a, data: d};
    do @(posedge clk); while (!bus_ack);
    rd = bus_rdata;
    bus_req <= 1'b0;
    do @(posedge clk); while (bus_ack);  // back to phase one
  endtask

  task automatic bus_write(input addr_t a, input data_t d);
    data_t unused;
    bus_transfer(1'b1, a, d, unused);
  endtask

  task automatic read_check(input addr_t a, input data_t exp, input string name);
    data_t rd;
    bus_transfer(1'b0, a, '0, rd);
    check_value(name, rd, exp);
  endtask

  // highest priority strictly above threshold, lowest id on a tie
  function automatic irq_id_t predict_claim(input logic [IRQ_NUM:1] lvl);
    irq_id_t id;
    prio_t   best;
    id = '0;
    best = thr_model;
    for (int i = 1; i <= IRQ_NUM; i++) begin
      if (lvl[i] && en_model[i] && (prio_model[i] > best)) begin
        best = prio_model[i];
        id = irq_id_t'(i);
      end
    end
    return id;
  endfunction

  // clear every pending bit and reopen all gateways
  task automatic drain_plic();
    data_t rd;
    ext_irq <= '0;
    for (int i = 1; i <= IRQ_NUM; i++) begin
      bus_write(addr_t'(ADDR_PRIO_BASE + i), 32'd7);
    end
    bus_write(ADDR_ENABLE, '1);
    bus_write(ADDR_THRESHOLD, '0);
    repeat (IRQ_NUM) bus_transfer(1'b0, ADDR_CLAIM, '0, rd);
    for (int i = 1; i <= IRQ_NUM; i++) begin
      bus_write(ADDR_CLAIM, data_t'(i));
    end
    read_check(ADDR_PENDING, '0, "bus_rdata pending after drain");
  endtask

  task automatic wait_trap_idle();
    int quiet;
    quiet = 0;
    while (quiet < 4) begin
      @(posedge clk);
      if (!trap_req && !trap_ack) quiet++;
      else quiet = 0;
    end
  endtask

  // --------------------
  // handshake rules
  assert property (@(posedge clk) disable iff (rst) $rose(bus_ack) |-> $past(bus_req))
    else report_failure("bus_ack rose without a bus request");
  assert property (@(posedge clk) disable iff (rst) bus_ack && bus_req |=> bus_ack)
    else report_failure("bus_ack dropped while bus_req was still high");
  assert property (@(posedge clk) disable iff (rst) trap_req && !trap_ack |=> trap_req)
    else report_failure("trap_req dropped before trap_ack");
  assert property (@(posedge clk) disable iff (rst) trap_req && trap_ack |=> !trap_req)
    else report_failure("trap_req stayed high after trap_ack");
  assert property (@(posedge clk) disable iff (rst) $rose(trap_req) |-> !$past(trap_ack))
    else report_failure("new trap request before trap_ack was released");

  // core agent, acks after 0 to 3 cycles
  initial begin
    int delay;
    trap_ack = 1'b0;
    forever begin
      @(posedge clk);
      if (trap_req && !trap_ack) begin
        trap_log.push_back(trap);
        delay = int'(take_bits(core_lfsr, 2));
        repeat (delay) @(posedge clk);
        trap_ack <= 1'b1;
        do @(posedge clk); while (trap_req);
        trap_ack <= 1'b0;
      end
    end
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Finished with errors");
    $finish;
  end

  // --------------------
  // stimulus
  initial begin
    data_t            d;
    logic [IRQ_NUM:1] lvl;
    int               n;
    int               k;
    int               waited;
    logic             e;
    logic             s;
    logic             t;
    logic             any;
    data_t            exp_cause;
    core_csr_t        csr;
    rst      = 1'b1;
    ext_irq  = '0;
    trigger  = 1'b0;
    bus_req  = 1'b0;
    bus_cmd  = '0;
    core_csr = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // reset values and readback
    read_check(ADDR_MSIP, '0, "bus_rdata msip");
    read_check(ADDR_MTIMECMP_LO, '1, "bus_rdata mtimecmp_lo");
    read_check(ADDR_MTIMECMP_HI, '1, "bus_rdata mtimecmp_hi");
    read_check(ADDR_MTIME_LO, '0, "bus_rdata mtime_lo");
    read_check(ADDR_MTIME_HI, '0, "bus_rdata mtime_hi");
    read_check(ADDR_PENDING, '0, "bus_rdata pending");
    read_check(ADDR_ENABLE, '0, "bus_rdata enable");
    read_check(ADDR_THRESHOLD, '0, "bus_rdata threshold");
    read_check(ADDR_CLAIM, '0, "bus_rdata claim");
    for (int i = 1; i <= IRQ_NUM; i++) begin
      read_check(addr_t'(ADDR_PRIO_BASE + i), '0, "bus_rdata prio");
    end
    repeat (3) begin
      d = take_bits(main_lfsr, 32);
      bus_write(ADDR_ENABLE, d);
      read_check(ADDR_ENABLE, d & (((32'd1 << IRQ_NUM) - 1) << 1), "bus_rdata enable");
      d = take_bits(main_lfsr, 32);
      bus_write(ADDR_THRESHOLD, d);
      read_check(ADDR_THRESHOLD, d & 32'h7, "bus_rdata threshold");
      d = take_bits(main_lfsr, 32);
      bus_write(ADDR_MSIP, d);
      read_check(ADDR_MSIP, d & 32'h1, "bus_rdata msip");
      check_value("irq_pend.sft", data_t'(irq_pend.sft), d & 32'h1);
      d = take_bits(main_lfsr, 32);
      bus_write(ADDR_MTIMECMP_LO, d);
      read_check(ADDR_MTIMECMP_LO, d, "bus_rdata mtimecmp_lo");
      d = take_bits(main_lfsr, 32);
      bus_write(ADDR_MTIMECMP_HI, d);
      read_check(ADDR_MTIMECMP_HI, d, "bus_rdata mtimecmp_hi");
      k = int'(take_bits(main_lfsr, 3)) % IRQ_NUM + 1;
      d = take_bits(main_lfsr, 32);
      bus_write(addr_t'(ADDR_PRIO_BASE + k), d);
      read_check(addr_t'(ADDR_PRIO_BASE + k), d & 32'h7, "bus_rdata prio");
    end
    bus_write(ADDR_PENDING, '1);  // read only
    read_check(ADDR_PENDING, '0, "bus_rdata pending");
    bus_write(ADDR_MTIME_LO, '1);
    read_check(ADDR_MTIME_LO, '0, "bus_rdata mtime_lo");
    bus_write(8'h05, '1);  // unmapped
    read_check(8'h05, '0, "bus_rdata unmapped");
    bus_write(ADDR_MSIP, '0);
    bus_write(ADDR_MTIMECMP_LO, '1);
    bus_write(ADDR_MTIMECMP_HI, '1);

    // --------------------
    // arbitration with random levels
    for (int r = 0; r < ROUNDS; r++) begin
      drain_plic();
      for (int i = 1; i <= IRQ_NUM; i++) begin
        prio_model[i] = prio_t'(take_bits(main_lfsr, PRIO_W));
        bus_write(addr_t'(ADDR_PRIO_BASE + i), data_t'(prio_model[i]));
      end
      d = take_bits(main_lfsr, IRQ_NUM);
      en_model = d[IRQ_NUM-1:0];
      thr_model = prio_t'(take_bits(main_lfsr, 2));  // low thresholds keep winners likely
      bus_write(ADDR_ENABLE, data_t'({en_model, 1'b0}));
      bus_write(ADDR_THRESHOLD, data_t'(thr_model));
      d = take_bits(main_lfsr, IRQ_NUM);
      lvl = d[IRQ_NUM-1:0];
      @(posedge clk);
      ext_irq <= lvl;
      repeat (2) @(posedge clk);
      ext_irq <= '0;
      read_check(ADDR_PENDING, data_t'({lvl, 1'b0}), "bus_rdata pending");
      read_check(ADDR_CLAIM, data_t'(predict_claim(lvl)), "bus_rdata claim id");
    end

    // --------------------
    // gateway stays closed until the right complete
    drain_plic();
    k = int'(take_bits(main_lfsr, 3)) % IRQ_NUM + 1;
    @(posedge clk);
    ext_irq[k] <= 1'b1;  // held high throughout
    repeat (2) @(posedge clk);
    read_check(ADDR_PENDING, 32'd1 << k, "bus_rdata pending before claim");
    read_check(ADDR_CLAIM, data_t'(k), "bus_rdata claim id");
    read_check(ADDR_PENDING, '0, "bus_rdata pending after claim");
    bus_write(ADDR_CLAIM, data_t'(k % IRQ_NUM + 1));
    bus_write(ADDR_CLAIM, '0);
    bus_write(ADDR_CLAIM, data_t'(IRQ_NUM + k));  // out of range
    repeat (4) @(posedge clk);
    read_check(ADDR_PENDING, '0, "bus_rdata pending after wrong complete");
    bus_write(ADDR_CLAIM, data_t'(k));
    repeat (2) @(posedge clk);
    read_check(ADDR_PENDING, 32'd1 << k, "bus_rdata pending after complete");
    @(posedge clk);
    ext_irq <= '0;

    // --------------------
    // timer
    n = int'(take_bits(main_lfsr, 3)) + 1;
    repeat (n) begin
      @(posedge clk);
      trigger <= 1'b1;
      repeat (2) @(posedge clk);
      trigger <= 1'b0;
      repeat (2) @(posedge clk);
    end
    repeat (3) @(posedge clk);
    read_check(ADDR_MTIME_LO, data_t'(n), "bus_rdata mtime_lo");
    read_check(ADDR_MTIME_HI, '0, "bus_rdata mtime_hi");
    bus_write(ADDR_MTIMECMP_HI, '0);
    check_value("irq_pend.tmr", data_t'(irq_pend.tmr), '0);
    bus_write(ADDR_MTIMECMP_LO, data_t'(n));
    check_value("irq_pend.tmr", data_t'(irq_pend.tmr), 32'd1);
    bus_write(ADDR_MTIMECMP_LO, data_t'(n - 1));
    check_value("irq_pend.tmr", data_t'(irq_pend.tmr), 32'd1);
    bus_write(ADDR_MTIMECMP_LO, data_t'(n + 1));
    check_value("irq_pend.tmr", data_t'(irq_pend.tmr), '0);

    // --------------------
    // core traps, source 1 stays pending and ENABLE bit 1 gates the ext line
    drain_plic();
    @(posedge clk);
    ext_irq[1] <= 1'b1;
    for (int it = 0; it < COMBOS; it++) begin
      d = take_bits(main_lfsr, 7);
      e = d[0];
      s = d[1];
      t = d[2];
      csr.mie   = (it < 10) ? 1'b1 : d[3];
      csr.meie  = d[4];
      csr.msie  = d[5];
      csr.mtie  = d[6];
      csr.mtvec = take_bits(main_lfsr, 32);
      csr.pc    = take_bits(main_lfsr, 32);
      bus_write(ADDR_ENABLE, e ? 32'h2 : 32'h0);
      bus_write(ADDR_MSIP, data_t'(s));
      bus_write(ADDR_MTIMECMP_LO, t ? 32'h0 : 32'hFFFF_FFFF);
      check_value("irq_pend", data_t'(irq_pend), data_t'({e, s, t}));
      any = 1'b1;
      exp_cause = '0;
      if (csr.mie && e && csr.meie) exp_cause = CAUSE_MEI;
      else if (csr.mie && s && csr.msie) exp_cause = CAUSE_MSI;
      else if (csr.mie && t && csr.mtie) exp_cause = CAUSE_MTI;
      else any = 1'b0;
      @(posedge clk);
      core_csr <= csr;
      if (any) begin
        waited = 0;
        while ((trap_log.size() == 0) && (waited < 20)) begin
          @(posedge clk);
          waited++;
        end
        assert (trap_log.size() != 0)
          else report_failure("no trap request for an enabled pending line");
        if (trap_log.size() != 0) begin
          check_value("trap.cause", trap_log[0].cause, exp_cause);
          check_value("trap.epc", trap_log[0].epc, csr.pc);
          check_value("trap.target", trap_log[0].target, csr.mtvec & 32'hFFFF_FFFC);
        end
      end else begin
        repeat (20) @(posedge clk);
        assert (trap_log.size() == 0)
          else report_failure("trap request although every line was masked");
      end
      @(posedge clk);
      core_csr.mie <= 1'b0;
      wait_trap_idle();
      trap_log.delete();
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
